//--- Makefile
VERILATOR ?= verilator
TOP       ?= udp_ptp_tx_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o sim_$(TOP)
	./$(BUILD_DIR)/sim_$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
source/eth_pkg.sv
source/udp_pkg.sv
source/payload_fifo.sv
source/header_builder.sv
source/gmii_tx_framer.sv
source/udp_ptp_tx.sv
tb/udp_ptp_tx_props.sv
tb/udp_ptp_tx_tb.sv

//--- source/eth_pkg.sv
// Ethernet framing definitions for the transmit path
// Byte-stream beat, MAC and EtherType types
// Addresses, preamble and gap constants

package eth_pkg;

    // One buffered stream beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_stream_t;

    typedef logic [47:0] mac_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [15:0] frame_len_t;

    typedef enum logic {
        SRC_PTP,
        SRC_UDP
    } src_sel_t;

    localparam mac_t LOCAL_MAC    = 48'h02_00_00_00_00_00;
    localparam mac_t PTP_DEST_MAC = 48'h01_1B_19_00_00_00;
    localparam mac_t BCAST_MAC    = 48'hFF_FF_FF_FF_FF_FF;

    localparam ethertype_t ETHERTYPE_PTP  = 16'h88F7;
    localparam ethertype_t ETHERTYPE_IPV4 = 16'h0800;

    // Seven preamble bytes then the SFD
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;
    localparam int         PREAMBLE_LEN  = 8;

    localparam int IFG_LEN     = 12;
    localparam int ETH_HDR_LEN = 14;

endpackage

//--- source/gmii_tx_framer.sv
// Round-robin frame arbiter and GMII transmit FSM
// Sends preamble, SFD, header and payload, then the inter-frame gap

`timescale 1ns/1ps

module gmii_tx_framer (
    input  logic                  logic_clk,
    input  logic                  rst,
    input  logic                  ptp_avail,
    input  logic                  udp_avail,
    input  eth_pkg::frame_len_t   ptp_len,
    input  eth_pkg::frame_len_t   udp_len,
    input  eth_pkg::byte_stream_t ptp_head,
    input  eth_pkg::byte_stream_t udp_head,
    output logic                  ptp_pop,
    output logic                  udp_pop,
    output logic                  hdr_start,
    output eth_pkg::src_sel_t     hdr_sel,
    output eth_pkg::frame_len_t   hdr_len_out,
    output logic [5:0]            hdr_index,
    input  logic [7:0]            hdr_byte,
    input  logic [5:0]            hdr_len,
    output logic [7:0]            gmii_txd,
    output logic                  gmii_tx_en
);
    import eth_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        HEADER,
        PAYLOAD,
        GAP
    } state_t;

    // Each state names what is loaded into the output registers this cycle
    state_t       state;
    src_sel_t     grant;
    src_sel_t     last_served;
    src_sel_t     pick;
    logic [3:0]   cnt;
    logic [5:0]   hdr_idx;
    byte_stream_t head;

    // Source not served last wins a tie
    always_comb begin
        if (ptp_avail && udp_avail)
            pick = (last_served == SRC_PTP) ? SRC_UDP : SRC_PTP;
        else if (udp_avail)
            pick = SRC_UDP;
        else
            pick = SRC_PTP;
    end

    assign head      = (grant == SRC_UDP) ? udp_head : ptp_head;
    assign ptp_pop   = (state == PAYLOAD) && (grant == SRC_PTP);
    assign udp_pop   = (state == PAYLOAD) && (grant == SRC_UDP);
    assign hdr_index = hdr_idx;

    always_ff @(posedge logic_clk) begin
        if (rst) begin
            state       <= IDLE;
            grant       <= SRC_PTP;
            last_served <= SRC_UDP;
            cnt         <= '0;
            hdr_idx     <= '0;
            hdr_start   <= 1'b0;
            hdr_sel     <= SRC_PTP;
            hdr_len_out <= '0;
            gmii_txd    <= '0;
            gmii_tx_en  <= 1'b0;
        end else begin
            // High while the first preamble byte is on the wire
            hdr_start <= (state == PREAMBLE) && (cnt == '0);
            case (state)
                IDLE: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= '0;
                    if (ptp_avail || udp_avail) begin
                        grant       <= pick;
                        last_served <= pick;
                        hdr_sel     <= pick;
                        hdr_len_out <= (pick == SRC_UDP) ? udp_len : ptp_len;
                        cnt         <= '0;
                        state       <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    gmii_tx_en <= 1'b1;
                    gmii_txd   <= (cnt == 4'(PREAMBLE_LEN - 1)) ? SFD_BYTE : PREAMBLE_BYTE;
                    cnt        <= cnt + 4'd1;
                    if (cnt == 4'(PREAMBLE_LEN - 1)) begin
                        hdr_idx <= '0;
                        state   <= HEADER;
                    end
                end
                HEADER: begin
                    gmii_txd <= hdr_byte;
                    hdr_idx  <= hdr_idx + 6'd1;
                    if (hdr_idx == hdr_len - 6'd1) begin
                        state <= PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    gmii_txd <= head.data;
                    if (head.last) begin
                        cnt   <= '0;
                        state <= GAP;
                    end
                end
                GAP: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= '0;
                    cnt        <= cnt + 4'd1;
                    if (cnt == 4'(IFG_LEN - 1)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- source/header_builder.sv
// Per-frame header byte generator
// Ethernet header for PTP, Ethernet/IPv4/UDP header for UDP
// IPv4 header checksum computed when a frame starts

`timescale 1ns/1ps

module header_builder (
    input  logic              logic_clk,
    input  logic              rst,
    input  logic              start,
    input  eth_pkg::src_sel_t sel,
    input  eth_pkg::frame_len_t len,
    input  logic [5:0]        hdr_index,
    output logic [7:0]        hdr_byte,
    output logic [5:0]        hdr_len
);
    import eth_pkg::*;
    import udp_pkg::*;

    src_sel_t    sel_q;
    frame_len_t  len_q;
    logic [15:0] csum_q;
    logic [15:0] start_total;
    logic [19:0] csum_acc;
    logic [16:0] csum_fold;
    logic [15:0] csum_next;

    mac_t        dest_mac;
    ethertype_t  eth_type;
    ip_udp_hdr_t fields;
    logic [8*UDP_FRAME_HDR_LEN-1:0] hdr_bits;

    // Ones'-complement sum of the ten IPv4 header words, checksum field zero
    always_comb begin
        start_total = 16'(IP_HDR_LEN + UDP_HDR_LEN) + len;
        csum_acc = 20'h04500 + 20'(start_total) + 20'({IP_TTL, IP_PROTO_UDP})
                 + 20'(LOCAL_IP[31:16]) + 20'(LOCAL_IP[15:0])
                 + 20'(DEST_IP[31:16]) + 20'(DEST_IP[15:0]);
        csum_fold = 17'(csum_acc[15:0]) + 17'(csum_acc[19:16]);
        csum_next = ~(csum_fold[15:0] + 16'(csum_fold[16]));
    end

    always_ff @(posedge logic_clk) begin
        if (rst) begin
            sel_q <= SRC_PTP;
        end else if (start) begin
            sel_q <= sel;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (start) begin
            len_q  <= len;
            csum_q <= csum_next;
        end
    end

    assign dest_mac = (sel_q == SRC_UDP) ? BCAST_MAC : PTP_DEST_MAC;
    assign eth_type = (sel_q == SRC_UDP) ? ETHERTYPE_IPV4 : ETHERTYPE_PTP;
    assign hdr_len  = (sel_q == SRC_UDP) ? 6'(UDP_FRAME_HDR_LEN) : 6'(ETH_HDR_LEN);

    always_comb begin
        fields            = '0;
        fields.version    = 4'd4;
        fields.ihl        = 4'd5;
        fields.total_len  = 16'(IP_HDR_LEN + UDP_HDR_LEN) + len_q;
        fields.ttl        = IP_TTL;
        fields.proto      = IP_PROTO_UDP;
        fields.checksum   = csum_q;
        fields.src_ip     = LOCAL_IP;
        fields.dest_ip    = DEST_IP;
        fields.src_port   = UDP_SRC_PORT;
        fields.dest_port  = UDP_DEST_PORT;
        fields.udp_len    = 16'(UDP_HDR_LEN) + len_q;
    end

    assign hdr_bits = {dest_mac, LOCAL_MAC, eth_type, fields};

    // Byte 0 is the first on the wire
    always_comb begin
        if (int'(hdr_index) < UDP_FRAME_HDR_LEN)
            hdr_byte = hdr_bits[8*(UDP_FRAME_HDR_LEN - 1 - int'(hdr_index)) +: 8];
        else
            hdr_byte = 8'h00;
    end

endmodule

//--- source/payload_fifo.sv
// Frame-buffering byte FIFO
// Offers a frame only once its last beat is stored,
// with a queue of completed frame lengths

`timescale 1ns/1ps

module payload_fifo #(
    parameter int DEPTH     = 256,
    parameter int LEN_SLOTS = 4
) (
    input  logic                  logic_clk,
    input  logic                  rst,
    input  eth_pkg::byte_stream_t in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output eth_pkg::byte_stream_t head,
    input  logic                  pop,
    output logic                  frame_avail,
    output eth_pkg::frame_len_t   frame_len
);
    import eth_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam int LW = $clog2(LEN_SLOTS);

    byte_stream_t mem [DEPTH];
    frame_len_t   len_mem [LEN_SLOTS];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [LW:0] len_wr;
    logic [LW:0] len_rd;
    frame_len_t  cur_len;
    logic        full;
    logic        len_full;
    logic        accept;

    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign len_full = (len_wr[LW] != len_rd[LW]) && (len_wr[LW-1:0] == len_rd[LW-1:0]);
    assign in_ready = !full && !len_full;
    assign accept   = in_valid && in_ready;

    assign head        = mem[rd_ptr[AW-1:0]];
    assign frame_avail = (len_wr != len_rd);
    assign frame_len   = len_mem[len_rd[LW-1:0]];

    // Byte and length storage
    always_ff @(posedge logic_clk) begin
        if (accept) begin
            mem[wr_ptr[AW-1:0]] <= in_data;
        end
        if (accept && in_data.last) begin
            len_mem[len_wr[LW-1:0]] <= cur_len + 16'd1;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            len_wr  <= '0;
            len_rd  <= '0;
            cur_len <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
                // Length of the frame being written
                if (in_data.last) begin
                    len_wr  <= len_wr + 1'b1;
                    cur_len <= '0;
                end else begin
                    cur_len <= cur_len + 16'd1;
                end
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (head.last) begin
                    len_rd <= len_rd + 1'b1;
                end
            end
        end
    end

endmodule

//--- source/udp_pkg.sv
// IPv4/UDP transmit configuration
// Fixed addresses, ports, TTL and protocol
// Header lengths and the IPv4/UDP header field struct

package udp_pkg;

    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [31:0] DEST_IP  = {8'd255, 8'd255, 8'd255, 8'd255};

    localparam logic [15:0] UDP_SRC_PORT  = 16'd1234;
    localparam logic [15:0] UDP_DEST_PORT = 16'd5555;

    localparam logic [7:0] IP_TTL       = 8'd64;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;

    localparam int IP_HDR_LEN  = 20;
    localparam int UDP_HDR_LEN = 8;

    // Ethernet, IPv4 and UDP headers together
    localparam int UDP_FRAME_HDR_LEN = 42;

    localparam int MAX_PAYLOAD = 200;

    // IPv4 header followed by UDP header, in wire order
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  proto;
        logic [15:0] checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } ip_udp_hdr_t;

endpackage

//--- source/udp_ptp_tx.sv
// Transmit top level for the PTP and UDP streams
// Two frame buffers, header builder and GMII framer

`timescale 1ns/1ps

module udp_ptp_tx (
    input  logic                  logic_clk,
    input  logic                  rst,
    input  eth_pkg::byte_stream_t ptp_data,
    input  logic                  ptp_valid,
    output logic                  ptp_ready,
    input  eth_pkg::byte_stream_t udp_data,
    input  logic                  udp_valid,
    output logic                  udp_ready,
    output logic [7:0]            gmii_txd,
    output logic                  gmii_tx_en
);
    import eth_pkg::*;

    byte_stream_t ptp_head;
    byte_stream_t udp_head;
    frame_len_t   ptp_len;
    frame_len_t   udp_len;
    frame_len_t   hdr_len_out;
    src_sel_t     hdr_sel;
    logic         ptp_avail;
    logic         udp_avail;
    logic         ptp_pop;
    logic         udp_pop;
    logic         hdr_start;
    logic [5:0]   hdr_index;
    logic [5:0]   hdr_len;
    logic [7:0]   hdr_byte;

    payload_fifo ptp_fifo (
        .logic_clk(logic_clk), .rst(rst),
        .in_data(ptp_data), .in_valid(ptp_valid), .in_ready(ptp_ready),
        .head(ptp_head), .pop(ptp_pop),
        .frame_avail(ptp_avail), .frame_len(ptp_len)
    );

    payload_fifo udp_fifo (
        .logic_clk(logic_clk), .rst(rst),
        .in_data(udp_data), .in_valid(udp_valid), .in_ready(udp_ready),
        .head(udp_head), .pop(udp_pop),
        .frame_avail(udp_avail), .frame_len(udp_len)
    );

    header_builder hdr_builder (
        .logic_clk(logic_clk), .rst(rst),
        .start(hdr_start), .sel(hdr_sel), .len(hdr_len_out),
        .hdr_index(hdr_index), .hdr_byte(hdr_byte), .hdr_len(hdr_len)
    );

    gmii_tx_framer framer (
        .logic_clk(logic_clk), .rst(rst),
        .ptp_avail(ptp_avail), .udp_avail(udp_avail),
        .ptp_len(ptp_len), .udp_len(udp_len),
        .ptp_head(ptp_head), .udp_head(udp_head),
        .ptp_pop(ptp_pop), .udp_pop(udp_pop),
        .hdr_start(hdr_start), .hdr_sel(hdr_sel), .hdr_len_out(hdr_len_out),
        .hdr_index(hdr_index), .hdr_byte(hdr_byte), .hdr_len(hdr_len),
        .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en)
    );

endmodule

//--- tb/udp_ptp_tx_props.sv
// Concurrent assertions on the GMII framer
// Gap length, first enabled byte and pop only with a frame available

`timescale 1ns/1ps

module udp_ptp_tx_props (
    input logic       logic_clk,
    input logic       rst,
    input logic       gmii_tx_en,
    input logic [7:0] gmii_txd,
    input logic       ptp_pop,
    input logic       udp_pop,
    input logic       ptp_avail,
    input logic       udp_avail
);
    import eth_pkg::*;

    gap_held: assert property (@(posedge logic_clk) disable iff (rst)
        $fell(gmii_tx_en) |-> !gmii_tx_en [*IFG_LEN])
        else $error("gmii_tx_en rose inside the inter-frame gap");

    first_byte_preamble: assert property (@(posedge logic_clk) disable iff (rst)
        $rose(gmii_tx_en) |-> gmii_txd == PREAMBLE_BYTE)
        else $error("first enabled byte is not preamble");

    ptp_pop_avail: assert property (@(posedge logic_clk) disable iff (rst)
        ptp_pop |-> ptp_avail)
        else $error("ptp pop without a frame available");

    udp_pop_avail: assert property (@(posedge logic_clk) disable iff (rst)
        udp_pop |-> udp_avail)
        else $error("udp pop without a frame available");

endmodule

bind gmii_tx_framer udp_ptp_tx_props props (
    .logic_clk(logic_clk), .rst(rst),
    .gmii_tx_en(gmii_tx_en), .gmii_txd(gmii_txd),
    .ptp_pop(ptp_pop), .udp_pop(udp_pop),
    .ptp_avail(ptp_avail), .udp_avail(udp_avail)
);

//--- tb/udp_ptp_tx_tb.sv
// Testbench for the PTP/UDP GMII transmit path
// Table of frames, reference frame model, burst monitor and compare tasks

`timescale 1ns/1ps

module udp_ptp_tx_tb;
    import eth_pkg::*;
    import udp_pkg::*;

    localparam int NUM_TESTS = 10;

    typedef struct packed {
        src_sel_t    src;
        frame_len_t  len;
        logic [15:0] delay;
    } test_entry_t;

    logic         logic_clk;
    logic         rst;
    byte_stream_t ptp_data;
    logic         ptp_valid;
    logic         ptp_ready;
    byte_stream_t udp_data;
    logic         udp_valid;
    logic         udp_ready;
    logic [7:0]   gmii_txd;
    logic         gmii_tx_en;

    test_entry_t tests [NUM_TESTS];
    integer      seed;
    int          cycle = 0;
    int          limit = 0;
    int          tx_frames = 0;
    int          idle_cnt = 0;
    int          burst_start = 0;
    bit          seen_burst = 0;
    bit          saw_stall = 0;
    src_sel_t    prev_src = SRC_PTP;

    // Expected frame bytes and lengths per source
    logic [7:0] ptp_exp [$];
    logic [7:0] udp_exp [$];
    frame_len_t ptp_exp_len [$];
    frame_len_t udp_exp_len [$];
    int         ptp_done [$];
    int         udp_done [$];
    logic [7:0] cap [$];

    udp_ptp_tx dut (
        .logic_clk(logic_clk), .rst(rst),
        .ptp_data(ptp_data), .ptp_valid(ptp_valid), .ptp_ready(ptp_ready),
        .udp_data(udp_data), .udp_valid(udp_valid), .udp_ready(udp_ready),
        .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en)
    );

    initial begin
        logic_clk = 1'b0;
        forever #2 logic_clk = ~logic_clk;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_len(string name, frame_len_t got, frame_len_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic [15:0] ip_checksum(logic [15:0] total);
        logic [31:0] sum;
        sum = 32'h4500 + total + {IP_TTL, IP_PROTO_UDP}
            + LOCAL_IP[31:16] + LOCAL_IP[15:0] + DEST_IP[31:16] + DEST_IP[15:0];
        while (sum[31:16] != 0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    task automatic push_exp(src_sel_t src, logic [7:0] b);
        if (src == SRC_UDP)
            udp_exp.push_back(b);
        else
            ptp_exp.push_back(b);
    endtask

    task automatic push_word(src_sel_t src, logic [15:0] w);
        push_exp(src, w[15:8]);
        push_exp(src, w[7:0]);
    endtask

    // Reference frame from the framing rules
    task automatic build_expected(src_sel_t src, logic [7:0] pl [$]);
        logic [15:0] total;
        int          hlen;
        total = 16'(IP_HDR_LEN + UDP_HDR_LEN) + 16'(pl.size());
        hlen = (src == SRC_UDP) ? UDP_FRAME_HDR_LEN : ETH_HDR_LEN;
        for (int i = 0; i < PREAMBLE_LEN - 1; i++) push_exp(src, PREAMBLE_BYTE);
        push_exp(src, SFD_BYTE);
        for (int i = 5; i >= 0; i--) begin
            push_exp(src, (src == SRC_UDP) ? BCAST_MAC[8*i +: 8] : PTP_DEST_MAC[8*i +: 8]);
        end
        for (int i = 5; i >= 0; i--) push_exp(src, LOCAL_MAC[8*i +: 8]);
        if (src == SRC_UDP) begin
            push_word(src, ETHERTYPE_IPV4);
            push_word(src, 16'h4500);
            push_word(src, total);
            push_word(src, 16'h0000);
            push_word(src, 16'h0000);
            push_word(src, {IP_TTL, IP_PROTO_UDP});
            push_word(src, ip_checksum(total));
            push_word(src, LOCAL_IP[31:16]);
            push_word(src, LOCAL_IP[15:0]);
            push_word(src, DEST_IP[31:16]);
            push_word(src, DEST_IP[15:0]);
            push_word(src, UDP_SRC_PORT);
            push_word(src, UDP_DEST_PORT);
            push_word(src, 16'(UDP_HDR_LEN) + 16'(pl.size()));
            push_word(src, 16'h0000);
            udp_exp_len.push_back(frame_len_t'(PREAMBLE_LEN + hlen + pl.size()));
        end else begin
            push_word(src, ETHERTYPE_PTP);
            ptp_exp_len.push_back(frame_len_t'(PREAMBLE_LEN + hlen + pl.size()));
        end
        foreach (pl[i]) push_exp(src, pl[i]);
    endtask

    task automatic drive_beat(src_sel_t src, logic valid, byte_stream_t beat);
        if (src == SRC_UDP) begin
            udp_valid = valid;
            udp_data  = beat;
        end else begin
            ptp_valid = valid;
            ptp_data  = beat;
        end
    endtask

    task automatic send_frame(test_entry_t t);
        logic [7:0]   pl [$];
        byte_stream_t beat;
        logic         rdy;
        for (int i = 0; i < int'(t.len); i++) pl.push_back(8'($random(seed)));
        build_expected(t.src, pl);
        for (int i = 0; i < pl.size(); i++) begin
            beat.data = pl[i];
            beat.last = (i == pl.size() - 1);
            @(negedge logic_clk);
            drive_beat(t.src, 1'b1, beat);
            rdy = (t.src == SRC_UDP) ? udp_ready : ptp_ready;
            while (!rdy) begin
                saw_stall = 1'b1;
                @(negedge logic_clk);
                rdy = (t.src == SRC_UDP) ? udp_ready : ptp_ready;
            end
        end
        @(negedge logic_clk);
        drive_beat(t.src, 1'b0, '0);
        if (t.src == SRC_UDP)
            udp_done.push_back(cycle);
        else
            ptp_done.push_back(cycle);
    endtask

    // Compare one finished burst with the head frame of its source
    task automatic close_burst();
        src_sel_t   src;
        frame_len_t exp_len;
        int         other_front;
        if (cap.size() < PREAMBLE_LEN + ETH_HDR_LEN) abort_run("Burst too short to hold a header");
        if ({cap[20], cap[21]} == ETHERTYPE_PTP)
            src = SRC_PTP;
        else if ({cap[20], cap[21]} == ETHERTYPE_IPV4)
            src = SRC_UDP;
        else
            abort_run("Burst carries an unknown EtherType");
        if (src == SRC_UDP ? udp_exp_len.size() == 0 : ptp_exp_len.size() == 0)
            abort_run("Frame sent that was never queued at its source");
        exp_len = (src == SRC_UDP) ? udp_exp_len.pop_front() : ptp_exp_len.pop_front();
        check_len("gmii_tx_en burst length", frame_len_t'(cap.size()), exp_len);
        foreach (cap[i]) begin
            check_byte($sformatf("gmii_txd byte %0d", i), cap[i],
                       (src == SRC_UDP) ? udp_exp.pop_front() : ptp_exp.pop_front());
        end
        // A frame waiting at the other source must win the next grant
        if (tx_frames > 0 && src == prev_src) begin
            other_front = -1;
            if (src == SRC_UDP && ptp_done.size() != 0) other_front = ptp_done[0];
            if (src == SRC_PTP && udp_done.size() != 0) other_front = udp_done[0];
            if (other_front >= 0 && other_front + 4 <= burst_start)
                abort_run("Arbiter served the same source twice while the other waited");
        end
        if (src == SRC_UDP)
            void'(udp_done.pop_front());
        else
            void'(ptp_done.pop_front());
        prev_src = src;
        tx_frames++;
    endtask

    always @(posedge logic_clk) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle > limit) abort_run("Timeout waiting for all frames");
    end

    always @(negedge logic_clk) begin
        if (rst) begin
            idle_cnt = 0;
        end else if (gmii_tx_en) begin
            if (cap.size() == 0) begin
                if (seen_burst && idle_cnt < IFG_LEN) abort_run("Inter-frame gap too short");
                burst_start = cycle;
            end
            cap.push_back(gmii_txd);
        end else begin
            if (cap.size() != 0) begin
                close_burst();
                cap.delete();
                idle_cnt = 0;
                seen_burst = 1'b1;
            end
            idle_cnt++;
        end
    end

    initial begin
        seed      = 32'h71e9;
        rst       = 1'b1;
        ptp_data  = '0;
        ptp_valid = 1'b0;
        udp_data  = '0;
        udp_valid = 1'b0;
        tests[0] = '{SRC_PTP, 16'd1, 16'd3};
        tests[1] = '{SRC_UDP, 16'd1, 16'd0};
        tests[2] = '{SRC_PTP, 16'd60, 16'd5};
        // Three full-size frames to overfill the UDP buffer
        tests[3] = '{SRC_UDP, 16'(MAX_PAYLOAD), 16'd0};
        tests[4] = '{SRC_UDP, 16'(MAX_PAYLOAD), 16'd0};
        tests[5] = '{SRC_UDP, 16'(MAX_PAYLOAD), 16'd0};
        tests[6] = '{SRC_PTP, 16'd44, 16'd0};
        tests[7] = '{SRC_PTP, 16'd17, 16'd2};
        tests[8] = '{SRC_UDP, 16'd99, 16'd10};
        tests[9] = '{SRC_PTP, 16'(MAX_PAYLOAD), 16'd0};
        limit = 200;
        foreach (tests[i]) begin
            limit += PREAMBLE_LEN + UDP_FRAME_HDR_LEN + int'(tests[i].len) + IFG_LEN
                   + int'(tests[i].delay);
        end
        repeat (8) @(posedge logic_clk);
        @(negedge logic_clk);
        rst = 1'b0;
        @(negedge logic_clk);
        check_bit("gmii_tx_en", gmii_tx_en, 1'b0);
        check_byte("gmii_txd", gmii_txd, 8'h00);
        check_bit("ptp_ready", ptp_ready, 1'b1);
        check_bit("udp_ready", udp_ready, 1'b1);
        foreach (tests[i]) begin
            repeat (int'(tests[i].delay)) @(negedge logic_clk);
            send_frame(tests[i]);
        end
        while (tx_frames < NUM_TESTS) @(negedge logic_clk);
        if (!saw_stall) begin
            abort_run("Input ready never dropped during the UDP burst");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule
